/* src/uart_cfg_pkg.sv */
`default_nettype none

package uart_cfg_pkg;

    // 8N1 frame, eight data bits between one start and one stop bit.
    localparam int data_bits = 8;

    // Bit counter must reach data_bits, so it needs one extra bit.
    localparam int bit_count_width = 4;

    // 115200 baud from a 100 MHz clock.
    localparam int default_clks_per_bit = 868;

    // Wide enough for a full bit period at the default rate.
    localparam int baud_count_width = 12;

endpackage : uart_cfg_pkg

`default_nettype wire

/* src/uart_rx_ctrl_pkg.sv */
`default_nettype none

package uart_rx_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_START = 2'd1,
        ST_DATA  = 2'd2,
        ST_STOP  = 2'd3
    } rx_state_t;

    // Shared by the baud timer and the bit counter.
    typedef enum logic [1:0] {
        CNT_CLEAR = 2'b00,
        CNT_HOLD  = 2'b01,
        CNT_COUNT = 2'b11
    } cnt_op_t;

endpackage : uart_rx_ctrl_pkg

`default_nettype wire

/* src/uart_baud_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer
    import uart_cfg_pkg::*;
    import uart_rx_ctrl_pkg::*;
#(
    parameter int CLKS_PER_BIT = default_clks_per_bit
)
(
    input  wire     clk,
    input  wire     reset_b,
    input  cnt_op_t baud_op,
    input  wire     half_sel,
    output logic    baud_hit
);

    localparam logic [baud_count_width-1:0] half_target =
        baud_count_width'(CLKS_PER_BIT / 2 - 1);
    localparam logic [baud_count_width-1:0] full_target =
        baud_count_width'(CLKS_PER_BIT - 1);

    logic [baud_count_width-1:0] baud_cnt;
    logic [baud_count_width-1:0] target;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            baud_cnt <= '0;
        else
        begin
            case (baud_op)
                CNT_CLEAR: baud_cnt <= '0;
                CNT_COUNT: baud_cnt <= baud_cnt + 1'b1;
                default:   baud_cnt <= baud_cnt;
            endcase
        end
    end

    // Half a bit to find mid start, a full bit between later samples.
    assign target   = half_sel ? half_target : full_target;
    assign baud_hit = (baud_cnt == target);

endmodule : uart_baud_timer

`default_nettype wire

/* src/uart_rx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_ctrl
    import uart_rx_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     reset_b,
    input  wire     rx_sync,
    input  wire     baud_hit,
    input  wire     bits_done,
    output cnt_op_t baud_op,
    output logic    half_sel,
    output cnt_op_t bit_op,
    output logic    shift_en,
    output logic    push,
    output logic    frame_error
);

    rx_state_t state;
    rx_state_t state_next;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next  = state;
        baud_op     = CNT_HOLD;
        half_sel    = 1'b0;
        bit_op      = CNT_HOLD;
        shift_en    = 1'b0;
        push        = 1'b0;
        frame_error = 1'b0;

        case (state)
            ST_IDLE:
            begin
                if (!rx_sync)
                begin
                    baud_op    = CNT_CLEAR;
                    state_next = ST_START;
                end
            end

            ST_START:
            begin
                half_sel = 1'b1;
                baud_op  = CNT_COUNT;
                if (baud_hit)
                begin
                    // Line back high at mid start bit means a glitch.
                    if (rx_sync)
                    begin
                        state_next = ST_IDLE;
                    end
                    else
                    begin
                        baud_op    = CNT_CLEAR;
                        bit_op     = CNT_CLEAR;
                        state_next = ST_DATA;
                    end
                end
            end

            ST_DATA:
            begin
                baud_op = CNT_COUNT;
                if (bits_done)
                begin
                    // Baud counter keeps running, so the stop sample stays aligned.
                    state_next = ST_STOP;
                end
                else if (baud_hit)
                begin
                    baud_op  = CNT_CLEAR;
                    bit_op   = CNT_COUNT;
                    shift_en = 1'b1;
                end
            end

            ST_STOP:
            begin
                baud_op = CNT_COUNT;
                if (baud_hit)
                begin
                    baud_op     = CNT_CLEAR;
                    push        = rx_sync;
                    frame_error = !rx_sync;
                    state_next  = ST_IDLE;
                end
            end

            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule : uart_rx_ctrl

`default_nettype wire

/* src/uart_rx_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_datapath
    import uart_cfg_pkg::*;
    import uart_rx_ctrl_pkg::*;
#(
    parameter int CLKS_PER_BIT = default_clks_per_bit
)
(
    input  wire                  clk,
    input  wire                  reset_b,
    input  wire                  rx,
    input  cnt_op_t              baud_op,
    input  wire                  half_sel,
    input  cnt_op_t              bit_op,
    input  wire                  shift_en,
    output logic                 rx_sync,
    output logic                 baud_hit,
    output logic                 bits_done,
    output logic [data_bits-1:0] shift_data
);

    logic                       rx_meta;
    logic [bit_count_width-1:0] bit_cnt;

    // Line idles high, so the synchronizer resets to one.
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // LSB arrives first, so bits enter at the top and move down.
    always_ff @(posedge clk)
    begin
        if (shift_en)
            shift_data <= {rx_sync, shift_data[data_bits-1:1]};
    end

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
            bit_cnt <= '0;
        else
        begin
            case (bit_op)
                CNT_CLEAR: bit_cnt <= '0;
                CNT_COUNT: bit_cnt <= bit_cnt + 1'b1;
                default:   bit_cnt <= bit_cnt;
            endcase
        end
    end

    assign bits_done = (bit_cnt == bit_count_width'(data_bits));

    uart_baud_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) baud_timer_i (
        .clk      (clk),
        .reset_b  (reset_b),
        .baud_op  (baud_op),
        .half_sel (half_sel),
        .baud_hit (baud_hit)
    );

endmodule : uart_rx_datapath

`default_nettype wire

/* src/uart_rx_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_buffer
(
    input  wire        clk,
    input  wire        reset_b,
    input  wire        push,
    input  wire  [7:0] push_data,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  wire        rx_ready,
    output logic       overrun
);

    logic take;
    logic load;

    assign take = rx_valid && rx_ready;

    // A byte read in the same cycle frees the slot for the new one.
    assign load = push && (!rx_valid || take);

    always_ff @(posedge clk)
    begin
        if (load)
            rx_data <= push_data;
    end

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end
        else
        begin
            if (load)
                rx_valid <= 1'b1;
            else if (take)
                rx_valid <= 1'b0;

            // Held byte wins and the new one is lost.
            if (push && !load)
                overrun <= 1'b1;
            else if (take)
                overrun <= 1'b0;
        end
    end

endmodule : uart_rx_buffer

`default_nettype wire

/* src/uart_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top
    import uart_cfg_pkg::*;
    import uart_rx_ctrl_pkg::*;
#(
    parameter int CLKS_PER_BIT = default_clks_per_bit
)
(
    input  wire        clk,
    input  wire        reset_b,
    input  wire        rx,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  wire        rx_ready,
    output logic       frame_error,
    output logic       overrun
);

    logic                 rx_sync;
    logic                 baud_hit;
    logic                 bits_done;
    cnt_op_t              baud_op;
    logic                 half_sel;
    cnt_op_t              bit_op;
    logic                 shift_en;
    logic                 push;
    logic [data_bits-1:0] shift_data;

    uart_rx_ctrl ctrl_i (
        .clk         (clk),
        .reset_b     (reset_b),
        .rx_sync     (rx_sync),
        .baud_hit    (baud_hit),
        .bits_done   (bits_done),
        .baud_op     (baud_op),
        .half_sel    (half_sel),
        .bit_op      (bit_op),
        .shift_en    (shift_en),
        .push        (push),
        .frame_error (frame_error)
    );

    uart_rx_datapath #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) datapath_i (
        .clk        (clk),
        .reset_b    (reset_b),
        .rx         (rx),
        .baud_op    (baud_op),
        .half_sel   (half_sel),
        .bit_op     (bit_op),
        .shift_en   (shift_en),
        .rx_sync    (rx_sync),
        .baud_hit   (baud_hit),
        .bits_done  (bits_done),
        .shift_data (shift_data)
    );

    uart_rx_buffer buffer_i (
        .clk       (clk),
        .reset_b   (reset_b),
        .push      (push),
        .push_data (shift_data),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .overrun   (overrun)
    );

endmodule : uart_rx_top

`default_nettype wire

/* tb/tb_uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_rx;

    localparam int clks_per_bit   = 16;
    localparam int timeout_cycles = 40 * clks_per_bit;
    // Read delay that leaves the byte in the buffer for the next line.
    localparam int hold_delay     = 255;

    logic       clk = 1'b0;
    logic       reset_b;
    logic       rx;
    logic       rx_ready;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       frame_error;
    logic       overrun;

    int         valid_rises   = 0;
    int         error_pulses  = 0;
    logic       valid_q       = 1'b0;
    logic [7:0] captured_byte = 8'h00;
    logic [7:0] held_byte     = 8'h00;

    uart_rx_top #(
        .CLKS_PER_BIT (clks_per_bit)
    ) dut_i (
        .clk         (clk),
        .reset_b     (reset_b),
        .rx          (rx),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .frame_error (frame_error),
        .overrun     (overrun)
    );

    always #5 clk = ~clk;

    // Counts result events at falling edges, where the outputs are settled.
    always @(negedge clk)
    begin
        if (reset_b)
        begin
            if (rx_valid && !valid_q)
            begin
                valid_rises   <= valid_rises + 1;
                captured_byte <= rx_data;
            end
            if (frame_error)
                error_pulses <= error_pulses + 1;
            valid_q <= rx_valid;
        end
    end

    task automatic report_failure(input string what);
        $display("Failure at time %0t: %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "test stopped");
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR: time %0t: %s is 0x%02h, expected 0x%02h",
                     $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_bit(input logic level);
        @(posedge clk);
        #1 rx = level;
        repeat (clks_per_bit - 1) @(posedge clk);
    endtask

    // Start bit, eight data bits LSB first, then the stop level.
    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(data[i]);
        drive_bit(stop_level);
    endtask

    task automatic send_glitch();
        @(posedge clk);
        #1 rx = 1'b0;
        repeat (4) @(posedge clk);
        #1 rx = 1'b1;
        // Receiver must be back in idle before the real frame starts.
        repeat (2 * clks_per_bit) @(posedge clk);
    endtask

    task automatic set_ready(input logic level);
        if (rx_ready !== level)
        begin
            @(posedge clk);
            #1 rx_ready = level;
        end
    endtask

    task automatic wait_valid_rise(input int start_count);
        int cycles = 0;
        while (valid_rises == start_count && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (valid_rises == start_count)
            report_failure("rx_valid never rose after the frame");
    endtask

    task automatic wait_frame_error(input int start_count);
        int cycles = 0;
        while (error_pulses == start_count && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (error_pulses == start_count)
            report_failure("frame_error never pulsed for a low stop bit");
    endtask

    task automatic wait_overrun_set();
        int cycles = 0;
        while (overrun !== 1'b1 && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (overrun !== 1'b1)
            report_failure("overrun never went high with the buffer full");
    endtask

    task automatic wait_valid_low();
        int cycles = 0;
        while (rx_valid !== 1'b0 && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (rx_valid !== 1'b0)
            report_failure("rx_valid never dropped after rx_ready was raised");
    endtask

    task automatic read_held_byte(input int delay);
        repeat (delay) @(posedge clk);
        @(negedge clk);
        check_value("rx_valid", 8'(rx_valid), 8'd1);
        check_value("rx_data", rx_data, held_byte);
        @(posedge clk);
        #1 rx_ready = 1'b1;
        wait_valid_low();
        check_value("overrun", 8'(overrun), 8'd0);
        // A dropped byte must not appear once the slot is free.
        repeat (2) @(negedge clk);
        check_value("rx_valid", 8'(rx_valid), 8'd0);
    endtask

    task automatic run_line(input logic [7:0] data, input int stop_level, input int glitch,
                            input int read_delay, input int expect_valid,
                            input int expect_overrun);
        int start_rises;
        int start_errors;
        int gap_bits;
        start_rises  = valid_rises;
        start_errors = error_pulses;
        set_ready(read_delay == 0);
        gap_bits = $urandom % 4;
        repeat (gap_bits) drive_bit(1'b1);
        if (glitch != 0)
            send_glitch();
        send_frame(data, stop_level != 0);
        if (stop_level == 0)
            wait_frame_error(start_errors);
        else if (expect_valid != 0)
            wait_valid_rise(start_rises);
        else
            wait_overrun_set();
        @(negedge clk);
        check_value("rx_valid rises", 8'(valid_rises - start_rises), 8'(expect_valid));
        check_value("frame_error pulses", 8'(error_pulses - start_errors), 8'(stop_level == 0));
        check_value("overrun", 8'(overrun), 8'(expect_overrun));
        if (expect_valid != 0)
        begin
            check_value("rx_data", captured_byte, data);
            held_byte = data;
        end
        if (expect_overrun != 0)
        begin
            check_value("rx_valid", 8'(rx_valid), 8'd1);
            check_value("rx_data", rx_data, held_byte);
        end
        if (read_delay > 0 && read_delay != hold_delay)
            read_held_byte(read_delay);
        if (stop_level == 0)
            drive_bit(1'b1);
    endtask

    initial
    begin
        int          fd;
        int          fields;
        int          lines_run;
        int          stop_level;
        int          glitch;
        int          read_delay;
        int          expect_valid;
        int          expect_overrun;
        logic [7:0]  data;
        string       line;
        rx         = 1'b1;
        rx_ready   = 1'b0;
        reset_b    = 1'b0;
        lines_run  = 0;
        void'($urandom(32'hffc4_3392));
        repeat (5) @(posedge clk);
        #1 reset_b = 1'b1;
        @(negedge clk);
        check_value("rx_valid", 8'(rx_valid), 8'd0);
        check_value("frame_error", 8'(frame_error), 8'd0);
        check_value("overrun", 8'(overrun), 8'd0);
        fd = $fopen("tb/uart_rx_testdata.txt", "r");
        if (fd == 0)
            report_failure("cannot open tb/uart_rx_testdata.txt");
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line[0] != "#")
                begin
                    fields = $sscanf(line, "%h %d %d %d %d %d", data, stop_level, glitch,
                                     read_delay, expect_valid, expect_overrun);
                    if (fields != 6)
                        report_failure("malformed line in the test data file");
                    else
                    begin
                        run_line(data, stop_level, glitch, read_delay, expect_valid,
                                 expect_overrun);
                        lines_run++;
                    end
                end
            end
            $fclose(fd);
            if (lines_run == 0)
                report_failure("test data file holds no frames");
            else
            begin
                $display("Simulation PASSED");
                $finish;
            end
        end
    end

endmodule : tb_uart_rx

`default_nettype wire

/* tb/uart_rx_testdata.txt */
# byte(hex) stop_level glitch read_delay expect_valid expect_overrun
# read_delay 0 keeps rx_ready high, 255 leaves the byte unread for the next line
55 1 0 0 1 0
a3 1 0 0 1 0
00 1 0 0 1 0
ff 1 0 0 1 0
01 1 0 0 1 0
80 1 0 0 1 0
3c 0 0 0 0 0
c5 1 0 0 1 0
7e 1 1 0 1 0
e7 1 0 12 1 0
5a 1 0 255 1 0
a5 1 0 20 0 1
96 1 0 0 1 0
69 0 0 0 0 0
12 1 1 0 1 0
34 1 0 3 1 0
fe 1 0 0 1 0
0f 1 0 0 1 0

/* filelist.f */
src/uart_cfg_pkg.sv
src/uart_rx_ctrl_pkg.sv
src/uart_baud_timer.sv
src/uart_rx_ctrl.sv
src/uart_rx_datapath.sv
src/uart_rx_buffer.sv
src/uart_rx_top.sv
tb/tb_uart_rx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the UART receiver testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_uart_rx -f filelist.f -o sim_uart_rx

obj_dir/sim_uart_rx 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Failure reported, see sim.log"
    exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
    echo "Run ended without a result, see sim.log"
    exit 1
fi

echo "Run passed"
